/* common/cpuPkg.sv */
package cpuPkg;

    // machine word, also the address width
    localparam int dataWidth = 16;

    // register file geometry
    localparam int regCount = 16;
    localparam int regAddrWidth = 4;

    // instruction field positions
    localparam int opcodeLsb = 12;
    localparam int opcodeWidth = 4;
    localparam int rdLsb = 8;
    localparam int rsLsb = 4;
    localparam int rtLsb = 0;

    // immediate fields sit at the bottom of the word
    localparam int imm4Width = 4;
    localparam int imm8Width = 8;

    // opcodes that are implemented; any other value is skipped
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSgt  = 4'd1,
        opSub  = 4'd2,
        opSeq  = 4'd3,
        opJalr = 4'd4,
        opLui  = 4'd5,
        opJal  = 4'd6,
        opAddi = 4'd8,
        opLw   = 4'd9,
        opSw   = 4'd10,
        opBne  = 4'd11,
        opLli  = 4'd15
    } opcodeT;

endpackage

/* common/ctrlPkg.sv */
package ctrlPkg;

    // one state per cycle of an instruction
    typedef enum logic [4:0] {
        stFetch, stDecode,
        stAluAdd, stAluSub, stWrAlu, stWrSgt, stWrSeq,
        stJump, stJal, stJalr, stWrJump,
        stMemAddr, stLwRead, stLwWrite, stAddiWrite, stSwWrite,
        stBne, stLui, stLli, stImmWrite
    } ctrlStateT;

    // ALU operand A
    typedef enum logic [1:0] {
        srcAPc   = 2'd0,
        srcARegA = 2'd1,
        srcARegB = 2'd2,
        srcAZero = 2'd3
    } aluSrcAT;

    // ALU operand B; zero passes PC through unchanged
    typedef enum logic [1:0] {
        srcBReg  = 2'd0,
        srcBOne  = 2'd1,
        srcBImm  = 2'd2,
        srcBZero = 2'd3
    } aluSrcBT;

    typedef enum logic [1:0] {
        immSext4  = 2'd0,
        immSext8  = 2'd1,
        immUpper8 = 2'd2,
        immZext8  = 2'd3
    } immFmtT;

    // register file write data
    typedef enum logic [1:0] {
        wbAluOut  = 2'd0,
        wbMdr     = 2'd1,
        wbGreater = 2'd2,
        wbEqual   = 2'd3
    } wbSrcT;

    // next PC
    typedef enum logic [1:0] {
        pcAluResult = 2'd0,
        pcAluOut    = 2'd1,
        pcRegA      = 2'd2
    } pcSrcT;

endpackage

/* src/control/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
    input  logic             CLK,
    input  logic             Reset,
    input  cpuPkg::opcodeT   opcode,
    output logic             pcWrite,
    output logic             pcWriteCond,
    output logic             iorD,
    output logic             irWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             memFetch,
    output logic             regWrite,
    output logic             aluSub,
    output logic             regBSel,
    output ctrlPkg::aluSrcAT aluSrcA,
    output ctrlPkg::aluSrcBT aluSrcB,
    output ctrlPkg::immFmtT  immFmt,
    output ctrlPkg::wbSrcT   wbSrc,
    output ctrlPkg::pcSrcT   pcSrc
);

    import cpuPkg::*;
    import ctrlPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
            state <= stFetch;
        else
            state <= nextState;
    end

    // SW, BNE and LLI need rd on read port B
    assign regBSel = (opcode == opSw) || (opcode == opBne) || (opcode == opLli);

    always_comb
    begin
        nextState = stFetch;
        case (state)
            stFetch:
                nextState = stDecode;
            stDecode:
            begin
                case (opcode)
                    opAdd:                nextState = stAluAdd;
                    opSgt, opSub, opSeq:  nextState = stAluSub;
                    opJal, opJalr:        nextState = stJump;
                    opAddi, opLw, opSw:   nextState = stMemAddr;
                    opBne:                nextState = stBne;
                    opLui:                nextState = stLui;
                    opLli:                nextState = stLli;
                    default:              nextState = stFetch;
                endcase
            end
            stAluAdd:
                nextState = stWrAlu;
            stAluSub:
            begin
                case (opcode)
                    opSgt:   nextState = stWrSgt;
                    opSeq:   nextState = stWrSeq;
                    opSub:   nextState = stWrAlu;
                    default: nextState = stFetch;
                endcase
            end
            stJump:
            begin
                case (opcode)
                    opJal:   nextState = stJal;
                    opJalr:  nextState = stJalr;
                    default: nextState = stFetch;
                endcase
            end
            stMemAddr:
            begin
                case (opcode)
                    opAddi:  nextState = stAddiWrite;
                    opLw:    nextState = stLwRead;
                    opSw:    nextState = stSwWrite;
                    default: nextState = stFetch;
                endcase
            end
            stLwRead:
                nextState = stLwWrite;
            stLui, stLli:
                nextState = stImmWrite;
            // write-back states, BNE and stWrJump all end here
            default:
                nextState = stFetch;
        endcase
    end

    always_comb
    begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        iorD        = 1'b0;
        irWrite     = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memFetch    = 1'b0;
        regWrite    = 1'b0;
        aluSub      = 1'b0;
        aluSrcA     = srcAPc;
        aluSrcB     = srcBReg;
        immFmt      = immSext4;
        wbSrc       = wbAluOut;
        pcSrc       = pcAluResult;

        case (state)
            stFetch:
            begin
                memFetch = 1'b1;
                memRead  = 1'b1;
                aluSrcB  = srcBOne;
                // PC and IR hold while Reset is high
                irWrite  = !Reset;
                pcWrite  = !Reset;
            end
            stDecode:
            begin
                // branch target into ALUOut, needed only by BNE
                aluSrcB = srcBImm;
            end
            stAluAdd:
            begin
                aluSrcA = srcARegA;
            end
            stAluSub:
            begin
                aluSrcA = srcARegA;
                aluSub  = 1'b1;
            end
            stWrAlu, stAddiWrite, stImmWrite:
            begin
                regWrite = 1'b1;
            end
            stWrSgt:
            begin
                // flags come straight from A and B
                aluSrcA  = srcARegA;
                aluSub   = 1'b1;
                wbSrc    = wbGreater;
                regWrite = 1'b1;
            end
            stWrSeq:
            begin
                aluSrcA  = srcARegA;
                aluSub   = 1'b1;
                wbSrc    = wbEqual;
                regWrite = 1'b1;
            end
            stJump:
            begin
                // return address, PC already points past the jump
                aluSrcB = srcBZero;
            end
            stJal:
            begin
                aluSrcB  = srcBImm;
                immFmt   = immSext8;
                pcWrite  = 1'b1;
                regWrite = 1'b1;
            end
            stJalr:
            begin
                pcSrc    = pcRegA;
                pcWrite  = 1'b1;
                regWrite = 1'b1;
            end
            stMemAddr:
            begin
                aluSrcA = srcARegA;
                aluSrcB = srcBImm;
            end
            stLwRead:
            begin
                iorD    = 1'b1;
                memRead = 1'b1;
            end
            stLwWrite:
            begin
                wbSrc    = wbMdr;
                regWrite = 1'b1;
            end
            stSwWrite:
            begin
                iorD     = 1'b1;
                memWrite = 1'b1;
            end
            stBne:
            begin
                aluSrcA     = srcARegA;
                aluSub      = 1'b1;
                pcSrc       = pcAluOut;
                pcWriteCond = 1'b1;
            end
            stLui:
            begin
                aluSrcA = srcAZero;
                aluSrcB = srcBImm;
                immFmt  = immUpper8;
            end
            stLli:
            begin
                // old rd arrives on port B
                aluSrcA = srcARegB;
                aluSrcB = srcBImm;
                immFmt  = immZext8;
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* src/datapath/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                            CLK,
    input  logic                            Reset,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::dataWidth-1:0]    writeData,
    input  logic                            writeEnable,
    output logic [cpuPkg::dataWidth-1:0]    readDataA,
    output logic [cpuPkg::dataWidth-1:0]    readDataB
);

    import cpuPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (writeEnable)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // R0 is hardwired to zero on both read ports
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* src/datapath/datapath.sv */
`timescale 1ns/100ps

module datapath #(
    parameter logic [cpuPkg::dataWidth-1:0] resetVector = '0
) (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic                         pcWrite,
    input  logic                         pcWriteCond,
    input  logic                         iorD,
    input  logic                         irWrite,
    input  logic                         regWrite,
    input  logic                         aluSub,
    input  logic                         regBSel,
    input  ctrlPkg::aluSrcAT             aluSrcA,
    input  ctrlPkg::aluSrcBT             aluSrcB,
    input  ctrlPkg::immFmtT              immFmt,
    input  ctrlPkg::wbSrcT               wbSrc,
    input  ctrlPkg::pcSrcT               pcSrc,
    input  logic [cpuPkg::dataWidth-1:0] memRData,
    output cpuPkg::opcodeT               opcode,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWData
);

    import cpuPkg::*;
    import ctrlPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] ir;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] aluOut;

    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic [dataWidth-1:0] writeData;
    logic [regAddrWidth-1:0] readAddrB;

    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic aluGreater;
    logic aluEqual;
    logic [dataWidth-1:0] pcNext;
    logic pcLoad;

    // PC and IR hold the architectural position
    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
        begin
            pc <= resetVector;
            ir <= '0;
        end
        else
        begin
            if (pcLoad)
                pc <= pcNext;
            if (irWrite)
                ir <= memRData;
        end
    end

    // temporaries load every cycle
    always_ff @(posedge CLK)
    begin
        mdr    <= memRData;
        regA   <= readDataA;
        regB   <= readDataB;
        aluOut <= aluResult;
    end

    assign opcode = opcodeT'(ir[opcodeLsb +: opcodeWidth]);
    assign readAddrB = regBSel ? ir[rdLsb +: regAddrWidth] : ir[rtLsb +: regAddrWidth];

    regFile u_regFile (
        .CLK         (CLK),
        .Reset       (Reset),
        .readAddrA   (ir[rsLsb +: regAddrWidth]),
        .readAddrB   (readAddrB),
        .writeAddr   (ir[rdLsb +: regAddrWidth]),
        .writeData   (writeData),
        .writeEnable (regWrite),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    always_comb
    begin
        case (immFmt)
            immSext4:
                imm = {{(dataWidth-imm4Width){ir[imm4Width-1]}}, ir[imm4Width-1:0]};
            immSext8:
                imm = {{(dataWidth-imm8Width){ir[imm8Width-1]}}, ir[imm8Width-1:0]};
            immUpper8:
                imm = {ir[imm8Width-1:0], {(dataWidth-imm8Width){1'b0}}};
            default:
                imm = {{(dataWidth-imm8Width){1'b0}}, ir[imm8Width-1:0]};
        endcase
    end

    always_comb
    begin
        case (aluSrcA)
            srcAPc:   opA = pc;
            srcARegA: opA = regA;
            srcARegB: opA = regB;
            default:  opA = '0;
        endcase

        case (aluSrcB)
            srcBReg: opB = regB;
            srcBOne: opB = dataWidth'(1);
            srcBImm: opB = imm;
            default: opB = '0;
        endcase
    end

    // add/subtract with compare flags on the same operands
    assign aluResult  = aluSub ? (opA - opB) : (opA + opB);
    assign aluGreater = $signed(opA) > $signed(opB);
    assign aluEqual   = (opA == opB);

    always_comb
    begin
        case (wbSrc)
            wbAluOut:  writeData = aluOut;
            wbMdr:     writeData = mdr;
            wbGreater: writeData = dataWidth'(aluGreater);
            default:   writeData = dataWidth'(aluEqual);
        endcase

        case (pcSrc)
            pcAluOut: pcNext = aluOut;
            pcRegA:   pcNext = regA;
            default:  pcNext = aluResult;
        endcase
    end

    // BNE takes the branch when the operands differ
    assign pcLoad = pcWrite || (pcWriteCond && !aluEqual);

    assign memAddr  = iorD ? aluOut : pc;
    assign memWData = regB;

endmodule

/* src/multicycleCpu.sv */
`timescale 1ns/100ps

module multicycleCpu #(
    parameter logic [cpuPkg::dataWidth-1:0] resetVector = '0
) (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic [cpuPkg::dataWidth-1:0] memRData,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWData,
    output logic                         memRead,
    output logic                         memWrite,
    output logic                         memFetch
);

    import cpuPkg::*;
    import ctrlPkg::*;

    // control to datapath
    logic pcWrite;
    logic pcWriteCond;
    logic iorD;
    logic irWrite;
    logic regWrite;
    logic aluSub;
    logic regBSel;
    aluSrcAT aluSrcA;
    aluSrcBT aluSrcB;
    immFmtT immFmt;
    wbSrcT wbSrc;
    pcSrcT pcSrc;

    // datapath to control
    opcodeT opcode;

    controlUnit u_controlUnit (
        .CLK         (CLK),
        .Reset       (Reset),
        .opcode      (opcode),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iorD        (iorD),
        .irWrite     (irWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memFetch    (memFetch),
        .regWrite    (regWrite),
        .aluSub      (aluSub),
        .regBSel     (regBSel),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .immFmt      (immFmt),
        .wbSrc       (wbSrc),
        .pcSrc       (pcSrc)
    );

    datapath #(
        .resetVector (resetVector)
    ) u_datapath (
        .CLK         (CLK),
        .Reset       (Reset),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iorD        (iorD),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aluSub      (aluSub),
        .regBSel     (regBSel),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .immFmt      (immFmt),
        .wbSrc       (wbSrc),
        .pcSrc       (pcSrc),
        .memRData    (memRData),
        .opcode      (opcode),
        .memAddr     (memAddr),
        .memWData    (memWData)
    );

endmodule

/* test/controlUnit_assertions.sv */
`timescale 1ns/100ps

module controlUnitAssertions (
    input logic               CLK,
    input logic               Reset,
    input ctrlPkg::ctrlStateT state,
    input logic               memWrite,
    input logic               memFetch,
    input logic               iorD
);

    import ctrlPkg::*;

    // FSM parked in Fetch during reset
    resetInFetch: assert property (@(posedge CLK) Reset |-> state == stFetch)
        else $error("control state is not Fetch while Reset is high");

    storeOnlyWrite: assert property (@(posedge CLK) memWrite |-> state == stSwWrite)
        else $error("memWrite high outside the store state");

    // every write-back state hands over to the next fetch
    writeBackToFetch: assert property (@(posedge CLK) disable iff (Reset)
        (state inside {stWrAlu, stWrSgt, stWrSeq, stJal, stJalr, stWrJump,
                       stLwWrite, stAddiWrite, stSwWrite, stImmWrite})
        |=> state == stFetch)
        else $error("write-back state not followed by Fetch");

    fetchUsesPc: assert property (@(posedge CLK) !(memFetch && iorD))
        else $error("memFetch and iorD high together");

endmodule

bind controlUnit controlUnitAssertions u_controlUnitAssertions (
    .CLK      (CLK),
    .Reset    (Reset),
    .state    (state),
    .memWrite (memWrite),
    .memFetch (memFetch),
    .iorD     (iorD)
);

/* test/tbCpu.sv */
`timescale 1ns/100ps

module tbCpu;

    import cpuPkg::*;

    localparam logic [15:0] resetVector = 16'h0010;
    localparam int maxCycles = 2000;
    localparam int selfFetchLimit = 4;

    logic CLK;
    logic Reset;
    logic [15:0] memRData;
    logic [15:0] memAddr;
    logic [15:0] memWData;
    logic memRead;
    logic memWrite;
    logic memFetch;

    // memory as seen by the DUT, and the image it starts from
    logic [15:0] mem [256];
    logic [15:0] image [256];

    // instruction-level reference state
    logic [15:0] modelMem [256];
    logic [15:0] modelRegs [16];
    logic [15:0] modelPc;
    logic [31:0] expWrites [$];
    logic [15:0] expReads [$];
    logic [15:0] expCycles;
    logic [15:0] sinceFetch;
    int fetches;
    int selfFetches;
    integer seed;
    logic [15:0] at;

    multicycleCpu #(
        .resetVector (resetVector)
    ) u_multicycleCpu (
        .CLK      (CLK),
        .Reset    (Reset),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memFetch (memFetch)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // image is copied in while Reset is held
    always @(posedge CLK)
    begin
        if (Reset)
            mem <= image;
        else if (memWrite)
            mem[memAddr[7:0]] <= memWData;
    end

    assign memRData = mem[memAddr[7:0]];

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
        assert (expected === actual)
        else
            failRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic logic [15:0] sext4(logic [3:0] v);
        return {{12{v[3]}}, v};
    endfunction

    function automatic logic [15:0] sext8(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] rType(opcodeT op, logic [3:0] rd, logic [3:0] rs,
                                          logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic logic [15:0] iType(opcodeT op, logic [3:0] rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    // cycles from one fetch to the next
    function automatic logic [15:0] cyclesFor(logic [3:0] op);
        case (op)
            opBne:   return 16'd3;
            opLw:    return 16'd5;
            opAdd, opSgt, opSub, opSeq, opJalr, opLui, opJal, opAddi, opSw, opLli:
                     return 16'd4;
            default: return 16'd2;
        endcase
    endfunction

    task automatic put(logic [15:0] word);
        image[at[7:0]] = word;
        modelMem[at[7:0]] = word;
        at = at + 16'd1;
    endtask

    // R1 is the store pointer, it moves up one word per store
    task automatic storeReg(logic [3:0] r);
        put(rType(opSw, r, 4'd1, 4'd0));
        put(rType(opAddi, 4'd1, 4'd1, 4'd1));
    endtask

    task automatic writeReg(logic [3:0] r, logic [15:0] value);
        if (r != 4'd0)
            modelRegs[r] = value;
    endtask

    task automatic loadProgram();
        logic [31:0] rndA;
        logic [31:0] rndB;
        logic [15:0] t;
        for (int i = 0; i < 256; i++)
        begin
            image[i] = {~i[7:0], i[7:0]};
            modelMem[i] = {~i[7:0], i[7:0]};
        end
        rndA = $random(seed);
        rndB = $random(seed);
        at = resetVector;
        put(iType(opLui, 4'd1, 8'h00));
        put(iType(opLli, 4'd1, 8'hC0));
        put(iType(opLui, 4'd2, rndA[15:8]));
        put(iType(opLli, 4'd2, rndA[7:0]));
        put(iType(opLui, 4'd3, rndB[15:8]));
        put(iType(opLli, 4'd3, rndB[7:0]));
        storeReg(4'd2);
        storeReg(4'd3);
        // arithmetic and compares in both operand orders
        put(rType(opAdd, 4'd4, 4'd2, 4'd3));
        storeReg(4'd4);
        put(rType(opSub, 4'd5, 4'd2, 4'd3));
        storeReg(4'd5);
        put(rType(opSub, 4'd5, 4'd3, 4'd2));
        storeReg(4'd5);
        put(rType(opSgt, 4'd6, 4'd2, 4'd3));
        storeReg(4'd6);
        put(rType(opSgt, 4'd6, 4'd3, 4'd2));
        storeReg(4'd6);
        put(rType(opSeq, 4'd7, 4'd2, 4'd3));
        storeReg(4'd7);
        put(rType(opSeq, 4'd7, 4'd3, 4'd3));
        storeReg(4'd7);
        // round trips through memory
        put(rType(opLw, 4'd8, 4'd1, 4'hE));
        storeReg(4'd8);
        put(rType(opAddi, 4'd9, 4'd1, 4'hB));
        put(rType(opSw, 4'd2, 4'd9, 4'h7));
        put(rType(opLw, 4'd10, 4'd9, 4'h7));
        storeReg(4'd10);
        put(rType(opLw, 4'd11, 4'd1, 4'h5));
        storeReg(4'd11);
        // branches, taken and not taken
        put(rType(opBne, 4'd2, 4'd3, 4'h1));
        put(rType(opAddi, 4'd12, 4'd12, 4'h1));
        put(rType(opBne, 4'd2, 4'd2, 4'h1));
        put(rType(opAddi, 4'd12, 4'd12, 4'h2));
        storeReg(4'd12);
        // opcodes 7 and 12 are skipped
        put({4'd7, 4'd12, 4'd2, 4'd3});
        put({4'd12, 4'd2, 4'd12, 4'd12});
        storeReg(4'd12);
        storeReg(4'd2);
        put(iType(opJal, 4'd13, 8'h02));
        put(rType(opAddi, 4'd12, 4'd12, 4'h1));
        put(rType(opAddi, 4'd12, 4'd12, 4'h1));
        storeReg(4'd13);
        storeReg(4'd12);
        // forward over a link slot, then back into it
        put(iType(opJal, 4'd14, 8'h01));
        put(iType(opJal, 4'd0, 8'h04));
        storeReg(4'd14);
        put(iType(opJal, 4'd15, 8'hFC));
        put(rType(opAddi, 4'd12, 4'd12, 4'h1));
        storeReg(4'd15);
        storeReg(4'd0);
        put(rType(opAddi, 4'd0, 4'd2, 4'h5));
        storeReg(4'd0);
        t = at;
        put(iType(opLui, 4'd5, 8'h00));
        put(iType(opLli, 4'd5, t[7:0] + 8'd4));
        put(rType(opJalr, 4'd6, 4'd5, 4'h0));
        put(rType(opAddi, 4'd12, 4'd12, 4'h1));
        storeReg(4'd6);
        storeReg(4'd12);
        put(iType(opJal, 4'd0, 8'hFF));
    endtask

    task automatic executeModel();
        logic [15:0] ir;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] d;
        logic [15:0] ret;
        logic [15:0] addr;
        ir = modelMem[modelPc[7:0]];
        a = modelRegs[ir[7:4]];
        b = modelRegs[ir[3:0]];
        d = modelRegs[ir[11:8]];
        ret = modelPc + 16'd1;
        addr = a + sext4(ir[3:0]);
        modelPc = ret;
        case (ir[15:12])
            opAdd:  writeReg(ir[11:8], a + b);
            opSgt:  writeReg(ir[11:8], ($signed(a) > $signed(b)) ? 16'd1 : 16'd0);
            opSub:  writeReg(ir[11:8], a - b);
            opSeq:  writeReg(ir[11:8], (a == b) ? 16'd1 : 16'd0);
            opJalr:
            begin
                writeReg(ir[11:8], ret);
                modelPc = a;
            end
            opLui:  writeReg(ir[11:8], {ir[7:0], 8'h00});
            opJal:
            begin
                writeReg(ir[11:8], ret);
                modelPc = ret + sext8(ir[7:0]);
            end
            opAddi: writeReg(ir[11:8], addr);
            opLw:
            begin
                writeReg(ir[11:8], modelMem[addr[7:0]]);
                expReads.push_back(addr);
            end
            opSw:
            begin
                modelMem[addr[7:0]] = d;
                expWrites.push_back({addr, d});
            end
            opBne:
            begin
                if (d != a)
                    modelPc = ret + sext4(ir[3:0]);
            end
            opLli:  writeReg(ir[11:8], d + {8'h00, ir[7:0]});
            default:
            begin
            end
        endcase
    endtask

    // one call per falling edge, outputs are settled here
    task automatic checkCycle();
        logic [31:0] exp;
        logic [15:0] expAddr;
        logic [15:0] prevPc;
        sinceFetch = sinceFetch + 16'd1;
        if (memWrite)
        begin
            assert (expWrites.size() != 0)
            else
                failRun($sformatf("memory write at %h that no store asked for", memAddr));
            exp = expWrites.pop_front();
            checkValue("store address", exp[31:16], memAddr);
            checkValue("store data", exp[15:0], memWData);
        end
        // data reads come only from loads
        if (memRead && !memFetch)
        begin
            assert (expReads.size() != 0)
            else
                failRun($sformatf("memory read at %h that no load asked for", memAddr));
            expAddr = expReads.pop_front();
            checkValue("load address", expAddr, memAddr);
        end
        if (memFetch)
        begin
            checkValue("memRead on fetch", 16'd1, {15'd0, memRead});
            if (fetches > 0)
                checkValue("cycles per instruction", expCycles, sinceFetch);
            checkValue("fetch address", modelPc, memAddr);
            sinceFetch = 16'd0;
            fetches++;
            expCycles = cyclesFor(modelMem[modelPc[7:0]][15:12]);
            prevPc = modelPc;
            executeModel();
            if (modelPc == prevPc)
                selfFetches++;
        end
    endtask

    initial
    begin
        int cycles;
        seed = 32'h0705_db2a;
        Reset = 1'b1;
        modelPc = resetVector;
        for (int i = 0; i < 16; i++)
            modelRegs[i] = 16'h0000;
        fetches = 0;
        selfFetches = 0;
        sinceFetch = 16'd0;
        expCycles = 16'd0;
        loadProgram();

        for (int i = 0; i < 5; i++)
        begin
            @(negedge CLK);
            assert (!memWrite && memFetch && memRead)
            else
                failRun("memory write, or no fetch read, while Reset is held");
        end
        Reset = 1'b0;

        cycles = 0;
        while (selfFetches < selfFetchLimit && cycles < maxCycles)
        begin
            checkCycle();
            @(negedge CLK);
            cycles++;
        end

        if (selfFetches < selfFetchLimit)
            failRun("timeout, the program never reached its final jump");
        else if (expWrites.size() != 0)
            failRun("a store of the program never reached memory");
        else if (expReads.size() != 0)
            failRun("a load of the program never read memory");
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* src.f */
common/cpuPkg.sv
common/ctrlPkg.sv
src/control/controlUnit.sv
src/datapath/regFile.sv
src/datapath/datapath.sv
src/multicycleCpu.sv
test/controlUnit_assertions.sv
test/tbCpu.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tbCpu
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
